/* src/cpuPkg.sv */
package cpuPkg;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opAddi    = 6'h08,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    // Function codes under opSpecial
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluPassB
    } aluOp_t;

    typedef enum logic [3:0] {
        stFetchReq,
        stFetchWait,
        stDecode,
        stExecR,
        stExecI,
        stMemAddr,
        stMemReq,
        stMemWait,
        stWriteBack,
        stBranch,
        stJump
    } cpuState_t;

    // ALU operand A source
    typedef enum logic [1:0] {
        aSelPc,
        aSelRegA,
        aSelNpc
    } aSel_t;

    // ALU operand B source
    typedef enum logic [1:0] {
        bSelRegB,
        bSelSignImm,
        bSelZeroImm,
        bSelUpperImm
    } bSel_t;

    // R-type view of the IR; imm16 is IR[15:0] and target26 is IR[25:0]
    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } instrFields_t;

    typedef struct packed {
        logic   pcLd;
        logic   nPcLd;
        logic   irLd;
        logic   marLd;
        logic   mdrLd;
        logic   rfLd;
        aSel_t  aSel;
        bSel_t  bSel;
        aluOp_t aluOp;
        logic   destRd;
        logic   wbFromMdr;
        logic   nPcFromAlu;
        logic   nPcFromJump;
        logic   marFromPc;
    } ctrlSignals_t;

    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
    } memReq_t;

endpackage

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [31:0]    a_i,
    input  logic [31:0]    b_i,
    input  cpuPkg::aluOp_t op_i,
    output logic [31:0]    result_o,
    output logic           zero_o
);

    import cpuPkg::*;

    logic lessThan;

    // Signed compare for slt
    assign lessThan = ($signed(a_i) < $signed(b_i));

    always_comb begin
        case (op_i)
            aluAdd: begin
                result_o = a_i + b_i;
            end
            aluSub: begin
                result_o = a_i - b_i;
            end
            aluAnd: begin
                result_o = a_i & b_i;
            end
            aluOr: begin
                result_o = a_i | b_i;
            end
            aluSlt: begin
                result_o = {31'd0, lessThan};
            end
            aluPassB: begin
                result_o = b_i;
            end
            default: begin
                result_o = 32'd0;
            end
        endcase
    end

    // Also serves as the beq equality test
    assign zero_o = (result_o == 32'd0);

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [4:0]  rdAddrA_i,
    input  logic [4:0]  rdAddrB_i,
    input  logic [4:0]  wrAddr_i,
    input  logic [31:0] wrData_i,
    input  logic        wrEn_i,
    output logic [31:0] rdDataA_o,
    output logic [31:0] rdDataB_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i && (wrAddr_i != 5'd0)) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // Register zero is hardwired
    assign rdDataA_o = (rdAddrA_i == 5'd0) ? 32'd0 : regs[rdAddrA_i];
    assign rdDataB_o = (rdAddrB_i == 5'd0) ? 32'd0 : regs[rdAddrB_i];

endmodule

/* src/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  logic                 clk,
    input  logic                 reset_i,
    input  cpuPkg::instrFields_t instr_i,
    input  logic                 zero_i,
    input  logic                 memDone_i,
    output cpuPkg::ctrlSignals_t ctrl_o,
    output logic                 memRd_o,
    output logic                 memWr_o
);

    import cpuPkg::*;

    cpuState_t state;
    cpuState_t stateNext;
    logic      isLoad;
    logic      isStore;

    assign isLoad  = (instr_i.opcode == opLw);
    assign isStore = (instr_i.opcode == opSw);

    // Strobes are registered and show up in the first wait cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state   <= stFetchReq;
            memRd_o <= 1'b0;
            memWr_o <= 1'b0;
        end else begin
            state   <= stateNext;
            memRd_o <= (state == stFetchReq) || ((state == stMemReq) && isLoad);
            memWr_o <= (state == stMemReq) && isStore;
        end
    end

    always_comb begin
        stateNext    = state;
        ctrl_o       = '0;
        // Default compare rs - rt, used by beq in decode
        ctrl_o.aSel  = aSelRegA;
        ctrl_o.bSel  = bSelRegB;
        ctrl_o.aluOp = aluSub;

        case (state)
            stFetchReq: begin
                ctrl_o.marFromPc = 1'b1;
                stateNext        = stFetchWait;
            end

            stFetchWait: begin
                ctrl_o.marFromPc = 1'b1;
                ctrl_o.irLd      = 1'b1;
                if (memDone_i) begin
                    stateNext = stDecode;
                end
            end

            stDecode: begin
                // nPC takes PC plus 4
                ctrl_o.nPcLd = 1'b1;
                case (instr_i.opcode)
                    opSpecial: stateNext = stExecR;
                    opAddi, opOri, opLui: stateNext = stExecI;
                    opLw, opSw: stateNext = stMemAddr;
                    opJ: stateNext = stJump;
                    opBeq: begin
                        if (zero_i) begin
                            stateNext = stBranch;
                        end else begin
                            ctrl_o.pcLd = 1'b1;
                            stateNext   = stFetchReq;
                        end
                    end
                    default: begin
                        // Unknown opcode is skipped
                        ctrl_o.pcLd = 1'b1;
                        stateNext   = stFetchReq;
                    end
                endcase
            end

            stExecR: begin
                ctrl_o.rfLd   = 1'b1;
                ctrl_o.destRd = 1'b1;
                ctrl_o.pcLd   = 1'b1;
                stateNext     = stFetchReq;
                case (instr_i.funct)
                    fnAdd: ctrl_o.aluOp = aluAdd;
                    fnSub: ctrl_o.aluOp = aluSub;
                    fnAnd: ctrl_o.aluOp = aluAnd;
                    fnOr: ctrl_o.aluOp = aluOr;
                    fnSlt: ctrl_o.aluOp = aluSlt;
                    default: ctrl_o.rfLd = 1'b0;
                endcase
            end

            stExecI: begin
                ctrl_o.rfLd = 1'b1;
                ctrl_o.pcLd = 1'b1;
                stateNext   = stFetchReq;
                case (instr_i.opcode)
                    opOri: begin
                        ctrl_o.bSel  = bSelZeroImm;
                        ctrl_o.aluOp = aluOr;
                    end
                    opLui: begin
                        ctrl_o.bSel  = bSelUpperImm;
                        ctrl_o.aluOp = aluPassB;
                    end
                    default: begin
                        ctrl_o.bSel  = bSelSignImm;
                        ctrl_o.aluOp = aluAdd;
                    end
                endcase
            end

            stMemAddr: begin
                // Effective address into MAR, PC moves on early
                ctrl_o.bSel  = bSelSignImm;
                ctrl_o.aluOp = aluAdd;
                ctrl_o.marLd = 1'b1;
                ctrl_o.pcLd  = 1'b1;
                stateNext    = stMemReq;
            end

            stMemReq: begin
                stateNext = stMemWait;
            end

            stMemWait: begin
                ctrl_o.mdrLd = isLoad;
                if (memDone_i) begin
                    stateNext = isLoad ? stWriteBack : stFetchReq;
                end
            end

            stWriteBack: begin
                ctrl_o.rfLd      = 1'b1;
                ctrl_o.wbFromMdr = 1'b1;
                stateNext        = stFetchReq;
            end

            stBranch: begin
                // Target is nPC plus the word offset
                ctrl_o.aSel       = aSelNpc;
                ctrl_o.bSel       = bSelSignImm;
                ctrl_o.aluOp      = aluAdd;
                ctrl_o.nPcFromAlu = 1'b1;
                ctrl_o.nPcLd      = 1'b1;
                ctrl_o.pcLd       = 1'b1;
                stateNext         = stFetchReq;
            end

            stJump: begin
                ctrl_o.nPcFromJump = 1'b1;
                ctrl_o.nPcLd       = 1'b1;
                ctrl_o.pcLd        = 1'b1;
                stateNext          = stFetchReq;
            end

            default: begin
                stateNext = stFetchReq;
            end
        endcase
    end

endmodule

/* src/dataPath.sv */
`timescale 1ns/1ps

module dataPath #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  cpuPkg::ctrlSignals_t ctrl_i,
    input  logic [31:0]          memRData_i,
    input  logic                 memDone_i,
    output cpuPkg::instrFields_t instr_o,
    output logic                 zero_o,
    output logic [31:0]          memAddr_o,
    output logic [31:0]          memWData_o
);

    import cpuPkg::*;

    logic [31:0]  pc;
    logic [31:0]  nPc;
    instrFields_t ir;
    logic [31:0]  mar;
    logic [31:0]  mdr;

    logic [15:0]  imm16;
    logic [25:0]  target26;
    logic [31:0]  signImm;
    logic [31:0]  zeroImm;
    logic [31:0]  upperImm;
    logic [31:0]  pcPlus4;
    logic [31:0]  jumpTarget;
    logic [31:0]  nPcNext;
    logic [31:0]  regA;
    logic [31:0]  regB;
    logic [31:0]  aluA;
    logic [31:0]  aluB;
    logic [31:0]  aluResult;
    logic [4:0]   wrAddr;
    logic [31:0]  wrData;

    assign imm16    = ir[15:0];
    assign target26 = ir[25:0];
    assign signImm  = {{16{imm16[15]}}, imm16};
    assign zeroImm  = {16'h0000, imm16};
    assign upperImm = {imm16, 16'h0000};

    assign pcPlus4    = pc + 32'd4;
    assign jumpTarget = {nPc[31:28], target26, 2'b00};

    // Next PC: sequential, branch target from ALU, or jump target
    always_comb begin
        if (ctrl_i.nPcFromJump) begin
            nPcNext = jumpTarget;
        end else if (ctrl_i.nPcFromAlu) begin
            nPcNext = aluResult;
        end else begin
            nPcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc  <= RESET_PC;
            nPc <= RESET_PC + 32'd4;
        end else begin
            if (ctrl_i.pcLd) begin
                pc <= nPcNext;
            end
            if (ctrl_i.nPcLd) begin
                nPc <= nPcNext;
            end
        end
    end

    // IR and MDR capture read data only in the done cycle
    always_ff @(posedge clk) begin
        if (ctrl_i.irLd && memDone_i) begin
            ir <= instrFields_t'(memRData_i);
        end
        if (ctrl_i.marLd) begin
            mar <= aluResult;
        end
        if (ctrl_i.mdrLd && memDone_i) begin
            mdr <= memRData_i;
        end
    end

    always_comb begin
        case (ctrl_i.aSel)
            aSelPc: aluA = pc;
            aSelNpc: aluA = nPc;
            aSelRegA: aluA = regA;
            default: aluA = regA;
        endcase
        case (ctrl_i.bSel)
            // Branch offsets count words when added to nPC
            bSelSignImm: begin
                aluB = (ctrl_i.aSel == aSelNpc) ? {signImm[29:0], 2'b00} : signImm;
            end
            bSelZeroImm: aluB = zeroImm;
            bSelUpperImm: aluB = upperImm;
            default: aluB = regB;
        endcase
    end

    assign wrAddr = ctrl_i.destRd ? ir.rd : ir.rt;
    assign wrData = ctrl_i.wbFromMdr ? mdr : aluResult;

    registerFile uRegFile (
        .clk       (clk),
        .reset_i   (reset_i),
        .rdAddrA_i (ir.rs),
        .rdAddrB_i (ir.rt),
        .wrAddr_i  (wrAddr),
        .wrData_i  (wrData),
        .wrEn_i    (ctrl_i.rfLd),
        .rdDataA_o (regA),
        .rdDataB_o (regB)
    );

    alu uAlu (
        .a_i      (aluA),
        .b_i      (aluB),
        .op_i     (ctrl_i.aluOp),
        .result_o (aluResult),
        .zero_o   (zero_o)
    );

    assign instr_o    = ir;
    // PC drives the bus during fetch, MAR otherwise
    assign memAddr_o  = ctrl_i.marFromPc ? pc : mar;
    assign memWData_o = regB;

endmodule

/* src/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic [31:0]     memRData_i,
    input  logic            memDone_i,
    output cpuPkg::memReq_t memReq_o
);

    import cpuPkg::*;

    ctrlSignals_t ctrl;
    instrFields_t instr;
    logic         zero;
    logic         memRd;
    logic         memWr;
    logic [31:0]  memAddr;
    logic [31:0]  memWData;

    controlUnit uControl (
        .clk       (clk),
        .reset_i   (reset_i),
        .instr_i   (instr),
        .zero_i    (zero),
        .memDone_i (memDone_i),
        .ctrl_o    (ctrl),
        .memRd_o   (memRd),
        .memWr_o   (memWr)
    );

    dataPath #(
        .RESET_PC (RESET_PC)
    ) uDataPath (
        .clk        (clk),
        .reset_i    (reset_i),
        .ctrl_i     (ctrl),
        .memRData_i (memRData_i),
        .memDone_i  (memDone_i),
        .instr_o    (instr),
        .zero_o     (zero),
        .memAddr_o  (memAddr),
        .memWData_o (memWData)
    );

    // Memory request bundle
    assign memReq_o = '{rd: memRd, wr: memWr, addr: memAddr, wdata: memWData};

endmodule

/* dv/cpuChecker.sv */
`timescale 1ns/1ps

module cpuChecker #(
    parameter int LIST_BASE     = 64,
    parameter int STORE_TIMEOUT = 500,
    parameter int QUIET_CYCLES  = 200
) (
    input  logic            clk,
    input  logic            reset_i,
    input  cpuPkg::memReq_t memReq_i,
    output logic            done_o,
    output logic [31:0]     errCount_o
);

    import cpuPkg::*;

    // Same image as the memory, only the expected list is used
    logic [31:0] image [256];
    int          storeCount;

    task automatic compareStore(input logic [31:0] expAddr, input logic [31:0] expData);
        logic ok;
        ok = 1'b1;
        if (memReq_i.addr !== expAddr) begin
            $display("** Error at time %0t: memReq_o.addr expected %h, actual %h",
                     $time, expAddr, memReq_i.addr);
            ok = 1'b0;
        end
        if (memReq_i.wdata !== expData) begin
            $display("** Error at time %0t: memReq_o.wdata expected %h, actual %h",
                     $time, expData, memReq_i.wdata);
            ok = 1'b0;
        end
        if (ok) begin
            $display("Store %0d ok: [%h] = %h", storeCount, expAddr, expData);
        end else begin
            errCount_o = errCount_o + 1;
            $display("Store %0d mismatch", storeCount);
        end
    endtask

    initial begin
        int   idx;
        int   waitCycles;
        logic timedOut;
        done_o     = 1'b0;
        errCount_o = 32'd0;
        storeCount = 0;
        timedOut   = 1'b0;
        $readmemh("dv/programInput.hex", image);

        waitCycles = 0;
        while (reset_i !== 1'b0 && waitCycles < 1000) begin
            @(negedge clk);
            waitCycles++;
        end
        if (reset_i !== 1'b0) begin
            $display("Reset was never released");
            errCount_o = errCount_o + 1;
            timedOut   = 1'b1;
        end

        idx = LIST_BASE;
        while (!timedOut && idx < 255 && image[idx] !== 32'hFFFF_FFFF) begin
            storeCount++;
            waitCycles = 0;
            @(negedge clk);
            while (memReq_i.wr !== 1'b1 && waitCycles < STORE_TIMEOUT) begin
                @(negedge clk);
                waitCycles++;
            end
            if (memReq_i.wr === 1'b1) begin
                compareStore(image[idx], image[idx + 1]);
            end else begin
                $display("Timeout: store %0d to %h did not appear within %0d cycles",
                         storeCount, image[idx], STORE_TIMEOUT);
                errCount_o = errCount_o + 1;
                timedOut   = 1'b1;
            end
            idx += 2;
        end

        // Program ends in a jump to itself, so the bus must stay free of stores
        if (!timedOut) begin
            waitCycles = 0;
            @(negedge clk);
            while (memReq_i.wr !== 1'b1 && waitCycles < QUIET_CYCLES) begin
                @(negedge clk);
                waitCycles++;
            end
            if (memReq_i.wr === 1'b1) begin
                $display("Unexpected store to %h after the last expected store",
                         memReq_i.addr);
                errCount_o = errCount_o + 1;
            end else begin
                $display("No extra store in %0d cycles", QUIET_CYCLES);
            end
        end

        $display("Stores checked: %0d, errors: %0d", storeCount, errCount_o);
        done_o = 1'b1;
    end

endmodule

/* dv/tbCpu.sv */
`timescale 1ns/1ps

module tbCpu;

    import cpuPkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int DONE_TIMEOUT = 20000;

    logic        clk;
    logic        reset;
    logic [31:0] memRData = 32'd0;
    logic        memDone  = 1'b0;
    memReq_t     memReq;

    logic        checkDone;
    logic [31:0] errCount;

    // Memory model state
    logic [31:0] mem [MEM_WORDS];
    integer      seed;
    int          delay;
    logic        pending;
    int          waitCnt;
    logic [31:0] reqAddr;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Each strobe is answered 1 to 4 cycles later with a one-cycle done
    always @(posedge clk) begin
        if (reset) begin
            memDone <= 1'b0;
            pending <= 1'b0;
            waitCnt <= 0;
        end else begin
            memDone <= 1'b0;
            if (pending) begin
                if (waitCnt <= 1) begin
                    memDone  <= 1'b1;
                    memRData <= mem[reqAddr[9:2]];
                    pending  <= 1'b0;
                end else begin
                    waitCnt <= waitCnt - 1;
                end
            end else if (memReq.rd || memReq.wr) begin
                delay = 1 + ($unsigned($random(seed)) % 4);
                if (memReq.wr) begin
                    mem[memReq.addr[9:2]] <= memReq.wdata;
                end
                if (delay == 1) begin
                    memDone  <= 1'b1;
                    memRData <= mem[memReq.addr[9:2]];
                end else begin
                    pending <= 1'b1;
                    waitCnt <= delay - 1;
                    reqAddr <= memReq.addr;
                end
            end
        end
    end

    cpuTop #(
        .RESET_PC (32'h0000_0000)
    ) UUT (
        .clk        (clk),
        .reset_i    (reset),
        .memRData_i (memRData),
        .memDone_i  (memDone),
        .memReq_o   (memReq)
    );

    cpuChecker uChecker (
        .clk        (clk),
        .reset_i    (reset),
        .memReq_i   (memReq),
        .done_o     (checkDone),
        .errCount_o (errCount)
    );

    initial begin
        int cycles;
        reset = 1'b1;
        seed  = 32'hf8b96aaa;
        $readmemh("dv/programInput.hex", mem);
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        while (checkDone !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end

        if (checkDone === 1'b1 && errCount == 0) begin
            $display("All checks passed");
        end else begin
            if (checkDone !== 1'b1) begin
                $display("Timeout: checker still busy after %0d cycles", DONE_TIMEOUT);
            end
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
src/cpuPkg.sv
src/alu.sv
src/registerFile.sv
src/controlUnit.sv
src/dataPath.sv
src/cpuTop.sv
dv/cpuChecker.sv
dv/tbCpu.sv

/* dv/programInput.hex */
// Words 0x00-0x1F: program. Word 0x40 on: expected stores as address then data,
// ended by an all-ones address. Word 0xC0: data word read by lw
@00
20010007 2002FFFD                   // addi r1 = 7, addi r2 = -3
00221820 AC030200 00221822 AC030204 // add, sub with stores
00221824 AC030208 00221825 AC03020C // and, or with stores
0041182A AC030210 AC020214          // slt r3 = r2 < r1, store r2
34048001 AC040218 3C051234 AC05021C // ori, lui with stores
8C060300 AC060220                   // lw then sw of the loaded word
20000005 AC000224                   // write r0, store r0
10210001 AC020228                   // beq taken skips the wrong marker
10220001 AC01022C                   // beq not taken falls through
20E70001 AC070230 20080002 10E80001 // counter loop body
08000019 AC050234 0800001F          // j back, final marker, halt
@40
00000200 00000004
00000204 0000000A
00000208 00000005
0000020C FFFFFFFF
00000210 00000001
00000214 FFFFFFFD
00000218 00008001
0000021C 12340000
00000220 CAFEF00D
00000224 00000000
0000022C 00000007
00000230 00000001
00000230 00000002
00000234 12340000
FFFFFFFF
@C0
CAFEF00D
